// File: all.f
design/lc3b_types.sv
design/lc3b_ctrl_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/ex_logic.sv
design/shift_unit.sv
design/shift_counter.sv
design/exec_fsm.sv
design/lc3b_exec_top.sv
testbench/lc3b_exec_checker.sv
testbench/tb_lc3b_exec.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_lc3b_exec -o sim_lc3b
./obj_dir/sim_lc3b > sim.log 2>&1 || true
cat sim.log
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

// File: testbench/tb_lc3b_exec.sv
module tb_lc3b_exec;
	timeunit 1ns;
	timeprecision 100ps;
	import lc3b_types::*;

	logic clk;
	logic reset;
	logic instr_valid;
	lc3b_word instr;
	lc3b_word next_pc;
	logic busy;
	logic done;
	lc3b_word result;
	lc3b_word address;
	lc3b_cc cc;

	lc3b_word model_regs [8]; // Mirror of the register file.
	logic [2:0] model_cc;
	logic [31:0] seed = 32'ha011;
	int issued = 0;
	int cycles = 0;

	lc3b_exec_top dut0 (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.next_pc(next_pc), .busy(busy), .done(done), .result(result),
		.address(address), .cc(cc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * issued + 100) begin
			$display("Timeout: the run hung waiting for done");
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	function automatic lc3b_word next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[31:16];
	endfunction

	function automatic logic [2:0] cc_of(lc3b_word v);
		return {v[15], v == 16'h0, !v[15] && v != 16'h0};
	endfunction

	function automatic lc3b_word shift_model(lc3b_word v, int dir, int amt);
		lc3b_word r;
		r = v;
		for (int i = 0; i < amt; i++) begin
			if (dir == 0)
				r = r << 1;
			else if (dir == 1)
				r = r >> 1;
			else
				r = {r[15], r[15:1]};
		end
		return r;
	endfunction

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	// Drives one instruction, waits for done and checks the latency.
	// With junk set, a second strobe arrives while the DUT is busy.
	task automatic issue(lc3b_word ins, lc3b_word pc, int lat, bit junk);
		int n;
		n = 0;
		instr = ins;
		next_pc = pc;
		instr_valid = 1'b1;
		issued++;
		do begin
			@(posedge clk);
			#1;
			n++;
			check("busy", busy, 1'b1);
			instr_valid = junk && (n == 4);
			instr = (junk && n == 4) ? 16'h1e3f : ins;
		end while (!done);
		check("latency", n, lat);
		@(posedge clk);
		#1;
		check("busy", busy, 1'b0);
	endtask

	task automatic op_check(lc3b_word ins, lc3b_word exp, lc3b_reg dr, int lat, bit junk);
		issue(ins, 16'h0, lat, junk);
		check("result", result, exp);
		model_regs[dr] = exp;
		model_cc = cc_of(exp);
		check("cc", cc, model_cc);
	endtask

	// LEA with a zero offset copies next_pc into a register and leaves cc alone.
	task automatic load_reg(lc3b_reg r, lc3b_word v);
		issue({4'b1110, r, 9'd0}, v, 2, 1'b0);
		check("result", result, v);
		model_regs[r] = v;
		check("cc", cc, model_cc);
	endtask

	task automatic reset_test();
		check("busy", busy, 0);
		check("done", done, 0);
		check("cc", cc, 3'b010);
		for (int r = 0; r < 8; r++) begin
			op_check({4'b0001, 3'(r), 3'(r), 1'b1, 5'd0}, 16'h0, 3'(r), 2, 1'b0);
		end
	endtask

	task automatic alu_test();
		lc3b_word a;
		lc3b_word b;
		logic [4:0] imm;
		lc3b_word sx;
		for (int i = 0; i < 6; i++) begin
			a = next_rand();
			b = next_rand();
			imm = next_rand() % 32;
			sx = {{11{imm[4]}}, imm};
			load_reg(1, a);
			load_reg(2, b);
			op_check({4'b0001, 3'd3, 3'd1, 3'b000, 3'd2}, a + b, 3, 2, 1'b0);
			op_check({4'b0101, 3'd4, 3'd1, 3'b000, 3'd2}, a & b, 4, 2, 1'b0);
			op_check({4'b0001, 3'd5, 3'd1, 1'b1, imm}, a + sx, 5, 2, 1'b0);
			op_check({4'b0101, 3'd6, 3'd1, 1'b1, imm}, a & sx, 6, 2, 1'b0);
		end
	endtask

	task automatic shift_test();
		lc3b_word vals [2] = '{16'h8f31, 16'h3a5c};
		int amts [4] = '{0, 1, 7, 15};
		logic [1:0] mode;
		for (int v = 0; v < 2; v++) begin
			load_reg(1, vals[v]);
			op_check({4'b1001, 3'd2, 3'd1, 6'b111111}, ~vals[v], 2, 2, 1'b0);
			for (int d = 0; d < 3; d++) begin
				mode = (d == 0) ? 2'b00 : ((d == 1) ? 2'b01 : 2'b11); // Bit 5 arith, bit 4 right.
				for (int k = 0; k < 4; k++) begin
					op_check({4'b1101, 3'd3, 3'd1, mode, 4'(amts[k])},
						shift_model(vals[v], d, amts[k]), 3, 2 + amts[k], 1'b0);
				end
			end
		end
	endtask

	task automatic addr_test();
		lc3b_word pc;
		lc3b_word base;
		lc3b_word exp_addr;
		logic signed [8:0] o9;
		logic signed [10:0] o11;
		logic signed [5:0] o6;
		logic [7:0] vec;
		pc = next_rand();
		base = next_rand();
		o9 = 9'(next_rand());
		o11 = 11'(next_rand());
		o6 = 6'(next_rand());
		vec = 8'(next_rand());
		load_reg(3, base);
		exp_addr = pc + 16'(o9) * 2; // Addresses wrap at 16 bits.
		issue({4'b0000, 3'b111, o9}, pc, 2, 1'b0);
		check("address", address, exp_addr);
		issue({4'b1110, 3'd4, o9}, pc, 2, 1'b0);
		check("address", address, exp_addr);
		check("result", result, exp_addr);
		model_regs[4] = exp_addr;
		check("cc", cc, model_cc);
		op_check({4'b0001, 3'd5, 3'd4, 1'b1, 5'd0}, model_regs[4], 5, 2, 1'b0);
		exp_addr = pc + 16'(o11) * 2;
		issue({4'b0100, 1'b1, o11}, pc, 2, 1'b0);
		check("address", address, exp_addr);
		exp_addr = base + 16'(o6) * 2;
		issue({4'b0110, 3'd0, 3'd3, o6}, pc, 2, 1'b0);
		check("address", address, exp_addr);
		issue({4'b0111, 3'd0, 3'd3, o6}, pc, 2, 1'b0);
		check("address", address, exp_addr);
		exp_addr = base + 16'(o6);
		issue({4'b0010, 3'd0, 3'd3, o6}, pc, 2, 1'b0);
		check("address", address, exp_addr);
		issue({4'b1100, 3'd0, 3'd3, 6'd0}, pc, 2, 1'b0);
		check("address", address, base);
		issue({8'hf0, vec}, pc, 2, 1'b0);
		check("address", address, {7'd0, vec, 1'b0});
		check("cc", cc, model_cc);
	endtask

	task automatic overlap_test();
		lc3b_word a;
		a = next_rand();
		load_reg(1, a);
		op_check({4'b1101, 3'd2, 3'd1, 2'b00, 4'd15}, shift_model(a, 0, 15), 2, 17, 1'b1);
		for (int r = 0; r < 8; r++) begin
			op_check({4'b0001, 3'(r), 3'(r), 1'b1, 5'd0}, model_regs[r], 3'(r), 2, 1'b0);
		end
	endtask

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		next_pc = '0;
		model_cc = 3'b010;
		for (int r = 0; r < 8; r++) begin
			model_regs[r] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_test();
		alu_test();
		shift_test();
		addr_test();
		overlap_test();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule : tb_lc3b_exec

// File: testbench/lc3b_exec_checker.sv
module lc3b_exec_checker (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic done
);
	timeunit 1ns;
	timeprecision 100ps;

	// The writeback state lasts one cycle.
	done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	done_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
		else $error("done was high while busy was low");

	// Reset is synchronous, so the FSM is idle one edge later.
	reset_idle: assert property (@(posedge clk) reset |=> (!busy && !done))
		else $error("busy or done was high in the cycle after reset");

endmodule : lc3b_exec_checker

bind lc3b_exec_top lc3b_exec_checker chk0 (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done)
);

// File: design/lc3b_exec_top.sv
module lc3b_exec_top (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input lc3b_types::lc3b_word instr,
	input lc3b_types::lc3b_word next_pc,
	output logic busy,
	output logic done,
	output lc3b_types::lc3b_word result,
	output lc3b_types::lc3b_word address,
	output lc3b_types::lc3b_cc cc
);
	import lc3b_types::*;
	import lc3b_ctrl_pkg::*;

	lc3b_instr ir_q;
	lc3b_word next_pc_q;
	lc3b_control ctrl;
	lc3b_word sr1;
	lc3b_word sr2;
	lc3b_word alu_out;
	lc3b_word ex_addr;
	lc3b_word shifted;
	lc3b_word wdata;
	logic [3:0] shift_amount;
	logic capture;
	logic shift_load;
	logic shift_step;
	logic write_back;
	logic last;

	always_ff @(posedge clk) begin
		if (capture) begin
			ir_q <= instr;
			next_pc_q <= next_pc;
		end
	end

	instr_decoder decoder0 (.ir(ir_q), .ctrl(ctrl));

	reg_file regs0 (
		.clk(clk), .reset(reset),
		.sr1_idx(ir_q.op.sr1), .sr2_idx(ir_q.op.low[2:0]), .dr_idx(ir_q.op.dr),
		.wdata(wdata), .write(write_back && ctrl.reg_write), .set_cc(ctrl.set_cc),
		.sr1(sr1), .sr2(sr2), .cc(cc)
	);

	ex_logic ex0 (
		.ex_control_sig(ctrl), .ex_next_instruction(next_pc_q), .ex_ir(ir_q),
		.ex_sr1(sr1), .ex_sr2(sr2), .ex_address(ex_addr), .ex_alu_out(alu_out)
	);

	assign shift_amount = alu_out[3:0]; // The ALU passes the zero-extended amount for SHF.

	shift_unit shifter0 (
		.clk(clk), .reset(reset), .load(shift_load), .step(shift_step),
		.operand(sr1), .dir(ctrl.shift_dir), .shifted(shifted)
	);

	shift_counter counter0 (
		.clk(clk), .reset(reset), .load(shift_load), .step(shift_step),
		.amount(shift_amount), .last(last)
	);

	exec_fsm fsm0 (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .is_shift(ctrl.is_shift),
		.shift_nonzero(shift_amount != 4'd0), .last(last), .capture(capture),
		.shift_load(shift_load), .shift_step(shift_step), .write_back(write_back),
		.busy(busy), .done(done)
	);

	// A zero-amount shift still writes back, and then the unshifted operand is what was loaded.
	assign wdata = ctrl.is_shift ? shifted : (ctrl.write_address ? ex_addr : alu_out);

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			address <= '0;
		end else if (write_back) begin
			result <= wdata;
			address <= ex_addr;
		end
	end

endmodule : lc3b_exec_top

// File: design/exec_fsm.sv
module exec_fsm (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic is_shift,
	input logic shift_nonzero,
	input logic last,
	output logic capture,
	output logic shift_load,
	output logic shift_step,
	output logic write_back,
	output logic busy,
	output logic done
);
	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_shift,
		st_writeback
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: if (instr_valid) state_next = st_exec;
			st_exec: state_next = (is_shift && shift_nonzero) ? st_shift : st_writeback;
			st_shift: if (last) state_next = st_writeback;
			default: state_next = st_idle;
		endcase
	end

	assign capture = (state == st_idle) && instr_valid; // Strobes while busy fall here.
	assign shift_load = (state == st_exec);
	assign shift_step = (state == st_shift);
	assign write_back = (state == st_writeback);
	assign busy = (state != st_idle);
	assign done = (state == st_writeback);

endmodule : exec_fsm

// File: design/shift_counter.sv
module shift_counter (
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	input logic [3:0] amount,
	output logic last
);
	logic [3:0] count; // Steps left after the one in progress.

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (load)
			count <= amount - 4'd1; // Only used when the amount is nonzero.
		else if (step && count != '0)
			count <= count - 4'd1;
	end

	assign last = (count == '0);

endmodule : shift_counter

// File: design/shift_unit.sv
module shift_unit (
	input logic clk,
	input logic reset,
	input logic load,
	input logic step,
	input lc3b_types::lc3b_word operand,
	input lc3b_ctrl_pkg::lc3b_shift_dir dir,
	output lc3b_types::lc3b_word shifted
);
	import lc3b_ctrl_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			shifted <= '0;
		end else if (load) begin
			shifted <= operand;
		end else if (step) begin
			case (dir)
				shf_left: shifted <= {shifted[14:0], 1'b0};
				shf_right_arith: shifted <= {shifted[15], shifted[15:1]}; // Sign copies in.
				default: shifted <= {1'b0, shifted[15:1]};
			endcase
		end
	end

endmodule : shift_unit

// File: design/ex_logic.sv
module ex_logic (
	input lc3b_ctrl_pkg::lc3b_control ex_control_sig,
	input lc3b_types::lc3b_word ex_next_instruction,
	input lc3b_types::lc3b_word ex_ir,
	input lc3b_types::lc3b_word ex_sr1,
	input lc3b_types::lc3b_word ex_sr2,
	output lc3b_types::lc3b_word ex_address,
	output lc3b_types::lc3b_word ex_alu_out
);
	import lc3b_types::*;
	import lc3b_ctrl_pkg::*;

	lc3b_instr ir;
	lc3b_word base;
	lc3b_word offset;
	lc3b_word adj6;
	lc3b_word adj9;
	lc3b_word adj11;
	lc3b_word sext6;
	lc3b_word adj11_sext6;
	lc3b_word offset_sum;
	lc3b_word trap_vec;
	lc3b_word sext5;
	lc3b_word zext4;
	lc3b_word alu_a;
	lc3b_word alu_b;

	assign ir = ex_ir;

	// Word offsets are scaled by two, the byte offset of LDB and STB is not.
	assign adj6 = {{9{ir.addr.offset[5]}}, ir.addr.offset[5:0], 1'b0};
	assign adj9 = {{6{ir.addr.offset[8]}}, ir.addr.offset[8:0], 1'b0};
	assign adj11 = {{4{ir.addr.offset[10]}}, ir.addr.offset, 1'b0};
	assign sext6 = {{10{ir.addr.offset[5]}}, ir.addr.offset[5:0]};
	assign trap_vec = {7'b0, ir.addr.offset[7:0], 1'b0};

	assign sext5 = {{11{ir.op.low[4]}}, ir.op.low};
	assign zext4 = {12'b0, ir.op.low[3:0]};

	assign base = ex_control_sig.instrsr1_sel ? ex_sr1 : ex_next_instruction;
	assign adj11_sext6 = ex_control_sig.adj11sext6_sel ? sext6 : adj11;

	always_comb begin
		case (ex_control_sig.offset_sel)
			off_zero: offset = '0;
			off_adj6: offset = adj6;
			off_adj9: offset = adj9;
			default: offset = adj11_sext6;
		endcase
	end

	assign offset_sum = base + offset;

	assign alu_a = ex_control_sig.alua_sel ? ex_sr2 : ex_sr1;

	always_comb begin
		case (ex_control_sig.imm_sel)
			imm_sr2: alu_b = ex_sr2;
			imm_sext5: alu_b = sext5;
			imm_zext4: alu_b = zext4;
			default: alu_b = sext6;
		endcase
	end

	always_comb begin
		case (ex_control_sig.aluop)
			alu_add: ex_alu_out = alu_a + alu_b;
			alu_and: ex_alu_out = alu_a & alu_b;
			alu_not: ex_alu_out = ~alu_a;
			default: ex_alu_out = alu_b;
		endcase
	end

	always_comb begin
		case (ex_control_sig.address_sel)
			addr_trap: ex_address = trap_vec;
			addr_offset_sum: ex_address = offset_sum;
			default: ex_address = ex_alu_out;
		endcase
	end

endmodule : ex_logic

// File: design/reg_file.sv
module reg_file (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_reg sr1_idx,
	input lc3b_types::lc3b_reg sr2_idx,
	input lc3b_types::lc3b_reg dr_idx,
	input lc3b_types::lc3b_word wdata,
	input logic write,
	input logic set_cc,
	output lc3b_types::lc3b_word sr1,
	output lc3b_types::lc3b_word sr2,
	output lc3b_types::lc3b_cc cc
);
	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			cc <= 3'b010; // Zero flag after reset.
		end else if (write) begin
			regs[dr_idx] <= wdata;
			if (set_cc) begin
				cc.n <= wdata[15];
				cc.z <= (wdata == '0);
				cc.p <= !wdata[15] && (wdata != '0);
			end
		end
	end

	assign sr1 = regs[sr1_idx];
	assign sr2 = regs[sr2_idx];

endmodule : reg_file

// File: design/instr_decoder.sv
module instr_decoder (
	input lc3b_types::lc3b_instr ir,
	output lc3b_ctrl_pkg::lc3b_control ctrl
);
	import lc3b_types::*;
	import lc3b_ctrl_pkg::*;

	always_comb begin
		ctrl = '0;
		ctrl.address_sel = addr_offset_sum;
		case (ir.addr.opcode)
			op_add, op_and: begin
				ctrl.aluop = (ir.addr.opcode == op_add) ? alu_add : alu_and;
				ctrl.imm_sel = ir.op.imm ? imm_sext5 : imm_sr2;
				ctrl.address_sel = addr_alu;
				ctrl.reg_write = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.address_sel = addr_alu;
				ctrl.reg_write = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			op_shf: begin
				// The ALU passes the 4-bit amount through to the shift counter.
				ctrl.aluop = alu_pass_b;
				ctrl.imm_sel = imm_zext4;
				ctrl.address_sel = addr_alu;
				ctrl.is_shift = 1'b1;
				if (!ir.op.low[4])
					ctrl.shift_dir = shf_left;
				else
					ctrl.shift_dir = ir.op.imm ? shf_right_arith : shf_right_logical;
				ctrl.reg_write = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			op_br: ctrl.offset_sel = off_adj9;
			op_lea: begin
				ctrl.offset_sel = off_adj9;
				ctrl.reg_write = 1'b1;
				ctrl.write_address = 1'b1;
			end
			op_jsr: begin
				if (ir.addr.link)
					ctrl.offset_sel = off_adj11_or_sext6; // PC-relative form.
				else
					ctrl.instrsr1_sel = 1'b1; // JSRR, base register with no offset.
			end
			op_jmp: ctrl.instrsr1_sel = 1'b1;
			op_ldr, op_str, op_ldi, op_sti: begin
				ctrl.instrsr1_sel = 1'b1;
				ctrl.offset_sel = off_adj6;
			end
			op_ldb, op_stb: begin
				ctrl.instrsr1_sel = 1'b1;
				ctrl.offset_sel = off_adj11_or_sext6;
				ctrl.adj11sext6_sel = 1'b1; // Byte access, offset not scaled.
			end
			op_trap: ctrl.address_sel = addr_trap;
			default: ;
		endcase
	end

endmodule : instr_decoder

// File: design/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass_b
	} lc3b_aluop;

	typedef enum logic [1:0] {
		off_zero,
		off_adj6,
		off_adj9,
		off_adj11_or_sext6
	} lc3b_offset_sel;

	typedef enum logic [1:0] {
		addr_trap,
		addr_offset_sum,
		addr_alu
	} lc3b_addr_sel;

	typedef enum logic [1:0] {
		imm_sr2,
		imm_sext5,
		imm_zext4,
		imm_sext6
	} lc3b_imm_sel;

	typedef enum logic [1:0] {
		shf_left,
		shf_right_logical,
		shf_right_arith
	} lc3b_shift_dir;

	typedef struct packed {
		logic instrsr1_sel; // Adder base, 0 is the next-instruction address and 1 is sr1.
		lc3b_offset_sel offset_sel;
		logic adj11sext6_sel; // 1 picks the unscaled byte offset.
		lc3b_addr_sel address_sel;
		lc3b_imm_sel imm_sel;
		logic alua_sel; // ALU operand A, 0 is sr1 and 1 is sr2.
		lc3b_aluop aluop;
		logic is_shift;
		lc3b_shift_dir shift_dir;
		logic reg_write;
		logic write_address; // LEA writes the address instead of the ALU result.
		logic set_cc;
	} lc3b_control;

endpackage : lc3b_ctrl_pkg

// File: design/lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	typedef enum logic [3:0] {
		op_br = 4'b0000,
		op_add = 4'b0001,
		op_ldb = 4'b0010,
		op_stb = 4'b0011,
		op_jsr = 4'b0100,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_rti = 4'b1000,
		op_not = 4'b1001,
		op_ldi = 4'b1010,
		op_sti = 4'b1011,
		op_jmp = 4'b1100,
		op_shf = 4'b1101,
		op_lea = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef struct packed {
		logic n;
		logic z;
		logic p;
	} lc3b_cc;

	// Register view. For SHF, imm is the arithmetic bit and low[4] the direction.
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm;
		logic [4:0] low;
	} lc3b_operate;

	typedef struct packed {
		lc3b_opcode opcode;
		logic link; // JSR uses this bit to pick the offset form over JSRR.
		logic [10:0] offset; // Offsets and the trap vector are low slices of this.
	} lc3b_address;

	typedef union packed {
		lc3b_operate op;
		lc3b_address addr;
	} lc3b_instr;

endpackage : lc3b_types
